// ==== Bender.yml ====
package:
  name: decode_issue

sources:
  - design/issue_pkg.sv
  - design/instr_decoder.sv
  - design/issue_control.sv
  - design/operand_select.sv
  - design/decode_issue.sv
  - target: test
    files:
      - tests/decode_issue_chk.sv
      - tests/tb_decode_issue.sv

// ==== design/decode_issue.sv ====
////////////////////////////////////////
// Decode and issue stage top level
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_issue (
    input  logic                                  clk,
    input  logic                                  rst,
    input  issue_pkg::decode_packet_t             decode,
    output logic                                  decode_advance,
    input  issue_pkg::rs_data_t                   rs_data,
    input  issue_pkg::rs_busy_t                   rs_busy,
    input  issue_pkg::unit_vec_t                  unit_ready,
    input  logic                                  fetch_flush,
    input  logic                                  issue_hold,
    output issue_pkg::unit_vec_t                  issue_to,
    output logic                                  instruction_issued,
    output logic [1:0][issue_pkg::REG_ADDR_W-1:0] rs_addr,
    output issue_pkg::alu_inputs_t                alu_inputs,
    output issue_pkg::ls_inputs_t                 ls_inputs,
    output issue_pkg::branch_inputs_t             branch_inputs
);
    import issue_pkg::*;

    decoded_t     decoded;
    issue_entry_t entry;

    instr_decoder decoder_i (
        .decode  (decode),
        .decoded (decoded)
    );

    issue_control control_i (
        .clk                (clk),
        .rst                (rst),
        .decode             (decode),
        .decoded            (decoded),
        .rs_busy            (rs_busy),
        .unit_ready         (unit_ready),
        .fetch_flush        (fetch_flush),
        .issue_hold         (issue_hold),
        .decode_advance     (decode_advance),
        .entry              (entry),
        .issue_to           (issue_to),
        .instruction_issued (instruction_issued),
        .rs_addr            (rs_addr)
    );

    // Bundles follow the registered entry, valid alongside issue_to
    operand_select operands_i (
        .entry         (entry),
        .rs_data       (rs_data),
        .rs_busy       (rs_busy),
        .alu_inputs    (alu_inputs),
        .ls_inputs     (ls_inputs),
        .branch_inputs (branch_inputs)
    );

endmodule

`default_nettype wire

// ==== design/instr_decoder.sv ====
////////////////////////////////////////
// Combinational RV32I instruction decode
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
    input  issue_pkg::decode_packet_t decode,
    output issue_pkg::decoded_t       decoded
);
    import issue_pkg::*;

    logic [31:0]   instr;
    opcode_t       op;
    logic [2:0]    fn3;
    logic          is_lui;
    logic          is_auipc;
    logic          is_jal;
    logic          is_jalr;
    logic          is_branch;
    logic          is_load;
    logic          is_store;
    logic          is_arith_imm;
    logic          is_arith;
    logic          is_fence;
    logic          is_system;
    logic          upper_or_jump;
    logic          sub_op;
    alu_logic_op_t logic_op;
    logic [19:0]   jal_imm;
    logic [11:0]   br_imm;

    assign instr = decode.instruction;
    assign op    = opcode_t'(instr[6:2]);
    assign fn3   = instr[14:12];

    assign is_lui       = (op == LUI);
    assign is_auipc     = (op == AUIPC);
    assign is_jal       = (op == JAL);
    assign is_jalr      = (op == JALR);
    assign is_branch    = (op == BRANCH);
    assign is_load      = (op == LOAD);
    assign is_store     = (op == STORE);
    assign is_arith_imm = (op == ARITH_IMM);
    assign is_arith     = (op == ARITH);
    assign is_fence     = (op == FENCE);
    assign is_system    = (op == SYSTEM);

    // Opcode bit 2 marks LUI, AUIPC, JAL and JALR among ALU users
    assign upper_or_jump = instr[2];
    assign sub_op        = is_arith & instr[30] & (fn3 == ADD_SUB_FN3);

    assign jal_imm = {instr[31], instr[19:12], instr[20], instr[30:21]};
    assign br_imm  = {instr[31], instr[7], instr[30:25], instr[11:8]};

    always_comb begin
        case (fn3)
            XOR_FN3: logic_op = ALU_XOR;
            OR_FN3:  logic_op = ALU_OR;
            AND_FN3: logic_op = ALU_AND;
            default: logic_op = ALU_ADD;
        endcase
        // Upper immediates and link values go through the adder
        if (upper_or_jump)
            logic_op = ALU_ADD;
    end

    always_comb begin
        decoded.unit_needed = '0;
        decoded.unit_needed[UNIT_ALU] = is_arith | is_arith_imm | is_lui | is_auipc
                                      | is_jal | is_jalr;
        decoded.unit_needed[UNIT_BRANCH] = is_branch | is_jal | is_jalr;
        decoded.unit_needed[UNIT_LS]     = is_load | is_store;
        decoded.unit_needed[UNIT_SYS]    = is_system | is_fence;

        decoded.uses_rs1 = ~(is_lui | is_auipc | is_jal | is_fence | is_system);
        decoded.uses_rs2 = is_branch | is_store | is_arith;
        decoded.uses_rd  = ~(is_branch | is_store | is_fence | is_system);
        decoded.rs1      = instr[19:15];
        decoded.rs2      = instr[24:20];
        decoded.rd       = instr[11:7];
        decoded.fn3      = fn3;
        decoded.opcode   = op;

        decoded.logic_op     = logic_op;
        decoded.subtract     = ~upper_or_jump & ((fn3 == SLT_FN3) | (fn3 == SLTU_FN3) | sub_op);
        decoded.slt_path     = ~upper_or_jump & ((fn3 == SLT_FN3) | (fn3 == SLTU_FN3));
        decoded.shifter_path = ~upper_or_jump & ((fn3 == SLL_FN3) | (fn3 == SRL_SRA_FN3));
        decoded.lshift       = ~fn3[2];

        decoded.rs1_use_regfile = ~(is_lui | is_auipc | is_jal | is_jalr);
        decoded.rs2_use_regfile = ~(is_lui | is_auipc | is_jal | is_jalr | is_arith_imm);
        if (is_lui | is_auipc)
            decoded.alu_imm = {instr[31:12], 12'b0};
        else if (is_jal | is_jalr)
            decoded.alu_imm = 32'd4;
        else
            decoded.alu_imm = 32'(signed'(instr[31:20]));

        // Stores use the split S form
        decoded.ls_offset = instr[5] ? {instr[31:25], instr[11:7]} : instr[31:20];
        decoded.is_load   = is_load;
        decoded.is_store  = is_store;

        if (is_jalr)
            decoded.pc_offset = 21'(signed'(instr[31:20]));
        else if (is_jal)
            decoded.pc_offset = {jal_imm, 1'b0};
        else
            decoded.pc_offset = 21'(signed'({br_imm, 1'b0}));
        decoded.use_signed = ~((fn3 == BLTU_FN3) | (fn3 == BGEU_FN3));
        decoded.jal        = is_jal;
        decoded.jalr       = is_jalr;
    end

endmodule

`default_nettype wire

// ==== design/issue_control.sv ====
////////////////////////////////////////
// Issue-stage register, operand hazard
// check and unit issue strobes
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module issue_control (
    input  logic                                  clk,
    input  logic                                  rst,
    input  issue_pkg::decode_packet_t             decode,
    input  issue_pkg::decoded_t                   decoded,
    input  issue_pkg::rs_busy_t                   rs_busy,
    input  issue_pkg::unit_vec_t                  unit_ready,
    input  logic                                  fetch_flush,
    input  logic                                  issue_hold,
    output logic                                  decode_advance,
    output issue_pkg::issue_entry_t               entry,
    output issue_pkg::unit_vec_t                  issue_to,
    output logic                                  instruction_issued,
    output logic [1:0][issue_pkg::REG_ADDR_W-1:0] rs_addr
);
    import issue_pkg::*;

    logic            entry_valid;
    logic [XLEN-1:0] entry_pc;
    logic            entry_instr30;
    decoded_t        entry_decoded;

    logic            stage_ready;
    logic            issue_valid;
    logic            rs1_hazard;
    logic            rs2_hazard;
    logic            operands_ready;
    unit_vec_t       unit_operands_ready;
    unit_vec_t       target_unit;

    ////////////////////////////////////////
    // Stage advance
    // Take a new instruction when empty or when the current one leaves
    assign stage_ready    = ~issue_hold & (~entry_valid | instruction_issued);
    assign decode_advance = decode.valid & stage_ready;

    always_ff @(posedge clk) begin
        if (rst || fetch_flush)
            entry_valid <= 1'b0;
        else if (stage_ready)
            entry_valid <= decode.valid;
    end

    always_ff @(posedge clk) begin
        if (stage_ready) begin
            entry_pc      <= decode.pc;
            entry_instr30 <= decode.instruction[30];
            entry_decoded <= decoded;
        end
    end

    assign entry = '{
        valid:   entry_valid,
        pc:      entry_pc,
        instr30: entry_instr30,
        decoded: entry_decoded
    };

    // Register file read addresses for the instruction in the stage
    assign rs_addr = {entry_decoded.rs2, entry_decoded.rs1};

    ////////////////////////////////////////
    // Operand hazards
    assign rs1_hazard     = rs_busy.rs1_busy & entry_decoded.uses_rs1;
    assign rs2_hazard     = rs_busy.rs2_busy & entry_decoded.uses_rs2;
    assign operands_ready = ~rs1_hazard & ~rs2_hazard;

    // Load/store forwards a busy store value, so only rs1 matters
    always_comb begin
        unit_operands_ready = {NUM_UNITS{operands_ready}};
        unit_operands_ready[UNIT_LS] = ~rs1_hazard;
    end

    ////////////////////////////////////////
    // Unit selection
    // Jumps mark both ALU and branch; the branch unit takes them
    always_comb begin
        target_unit = entry_decoded.unit_needed;
        if (target_unit[UNIT_BRANCH])
            target_unit[UNIT_ALU] = 1'b0;
    end

    assign issue_valid = entry_valid & ~issue_hold & ~fetch_flush;

    assign issue_to = {NUM_UNITS{issue_valid}} & target_unit & unit_ready
                    & unit_operands_ready;
    assign instruction_issued = |issue_to;

endmodule

`default_nettype wire

// ==== design/issue_pkg.sv ====
////////////////////////////////////////
// Widths, enums and packed structs
// shared by the decode and issue stage
////////////////////////////////////////
`default_nettype none

package issue_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_UNITS  = 4;

    // fn3 encodings used by decode
    localparam logic [2:0] ADD_SUB_FN3 = 3'b000;
    localparam logic [2:0] SLL_FN3     = 3'b001;
    localparam logic [2:0] SLT_FN3     = 3'b010;
    localparam logic [2:0] SLTU_FN3    = 3'b011;
    localparam logic [2:0] XOR_FN3     = 3'b100;
    localparam logic [2:0] SRL_SRA_FN3 = 3'b101;
    localparam logic [2:0] OR_FN3      = 3'b110;
    localparam logic [2:0] AND_FN3     = 3'b111;
    localparam logic [2:0] BLTU_FN3    = 3'b110;
    localparam logic [2:0] BGEU_FN3    = 3'b111;

    // Major opcode, instruction bits 6..2
    typedef enum logic [4:0] {
        LOAD      = 5'b00000,
        FENCE     = 5'b00011,
        ARITH_IMM = 5'b00100,
        AUIPC     = 5'b00101,
        STORE     = 5'b01000,
        ARITH     = 5'b01100,
        LUI       = 5'b01101,
        BRANCH    = 5'b11000,
        JALR      = 5'b11001,
        JAL       = 5'b11011,
        SYSTEM    = 5'b11100
    } opcode_t;

    typedef enum logic [1:0] {
        UNIT_ALU    = 2'd0,
        UNIT_BRANCH = 2'd1,
        UNIT_LS     = 2'd2,
        UNIT_SYS    = 2'd3
    } unit_e;

    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_XOR = 2'b01,
        ALU_OR  = 2'b10,
        ALU_AND = 2'b11
    } alu_logic_op_t;

    typedef logic [NUM_UNITS-1:0] unit_vec_t;

    ////////////////////////////////////////
    // Stage records
    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instruction;
    } decode_packet_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
    } rs_data_t;

    typedef struct packed {
        logic rs1_busy;
        logic rs2_busy;
    } rs_busy_t;

    typedef struct packed {
        unit_vec_t             unit_needed;
        logic                  uses_rs1;
        logic                  uses_rs2;
        logic                  uses_rd;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rd;
        logic [2:0]            fn3;
        opcode_t               opcode;
        // ALU controls
        alu_logic_op_t         logic_op;
        logic                  subtract;
        logic                  slt_path;
        logic                  shifter_path;
        logic                  lshift;
        // Operand sources
        logic                  rs1_use_regfile;
        logic                  rs2_use_regfile;
        logic [XLEN-1:0]       alu_imm;
        // Load/store
        logic [11:0]           ls_offset;
        logic                  is_load;
        logic                  is_store;
        // Branch
        logic [20:0]           pc_offset;
        logic                  use_signed;
        logic                  jal;
        logic                  jalr;
    } decoded_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic            instr30;
        decoded_t        decoded;
    } issue_entry_t;

    ////////////////////////////////////////
    // Unit operand bundles
    typedef struct packed {
        logic [XLEN:0]   in1;
        logic [XLEN:0]   in2;
        logic [XLEN-1:0] shifter_in;
        logic [4:0]      shift_amount;
        alu_logic_op_t   logic_op;
        logic            subtract;
        logic            arith;
        logic            lshift;
        logic            shifter_path;
        logic            slt_path;
    } alu_inputs_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [11:0]     offset;
        logic [2:0]      fn3;
        logic            load;
        logic            store;
        logic            forwarded_store;
    } ls_inputs_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] pc;
        logic [20:0]     pc_offset;
        logic [2:0]      fn3;
        logic            use_signed;
        logic            jal;
        logic            jalr;
    } branch_inputs_t;

endpackage

`default_nettype wire

// ==== design/operand_select.sv ====
////////////////////////////////////////
// ALU, load/store and branch operands
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module operand_select (
    input  issue_pkg::issue_entry_t   entry,
    input  issue_pkg::rs_data_t       rs_data,
    input  issue_pkg::rs_busy_t       rs_busy,
    output issue_pkg::alu_inputs_t    alu_inputs,
    output issue_pkg::ls_inputs_t     ls_inputs,
    output issue_pkg::branch_inputs_t branch_inputs
);
    import issue_pkg::*;

    decoded_t        dec;
    logic [XLEN-1:0] alu_rs1;
    logic [XLEN-1:0] alu_rs2;
    logic            pc_as_in1;
    logic            unsigned_cmp;

    assign dec = entry.decoded;

    ////////////////////////////////////////
    // ALU
    // AUIPC and the jumps add to the pc, LUI adds to zero
    assign pc_as_in1 = (dec.opcode == AUIPC) | (dec.opcode == JAL) | (dec.opcode == JALR);

    always_comb begin
        if (dec.rs1_use_regfile)
            alu_rs1 = rs_data.rs1;
        else if (pc_as_in1)
            alu_rs1 = entry.pc;
        else
            alu_rs1 = '0;
    end

    assign alu_rs2      = dec.rs2_use_regfile ? rs_data.rs2 : dec.alu_imm;
    assign unsigned_cmp = dec.slt_path & (dec.fn3 == SLTU_FN3);

    always_comb begin
        // Extra top bit lets the adder do signed and unsigned compare
        alu_inputs.in1          = {alu_rs1[XLEN-1] & ~unsigned_cmp, alu_rs1};
        alu_inputs.in2          = {alu_rs2[XLEN-1] & ~unsigned_cmp, alu_rs2};
        alu_inputs.shifter_in   = rs_data.rs1;
        alu_inputs.shift_amount = (dec.opcode == ARITH) ? rs_data.rs2[4:0] : dec.rs2;
        alu_inputs.logic_op     = dec.logic_op;
        alu_inputs.subtract     = dec.subtract;
        alu_inputs.arith        = rs_data.rs1[XLEN-1] & entry.instr30;
        alu_inputs.lshift       = dec.lshift;
        alu_inputs.shifter_path = dec.shifter_path;
        alu_inputs.slt_path     = dec.slt_path;
    end

    ////////////////////////////////////////
    // Load/store
    always_comb begin
        ls_inputs.rs1    = rs_data.rs1;
        ls_inputs.rs2    = rs_data.rs2;
        ls_inputs.offset = dec.ls_offset;
        ls_inputs.fn3    = dec.fn3;
        ls_inputs.load   = dec.is_load;
        ls_inputs.store  = dec.is_store;
        // Store data still in flight, picked up later by the unit
        ls_inputs.forwarded_store = rs_busy.rs2_busy & dec.uses_rs2;
    end

    ////////////////////////////////////////
    // Branch
    always_comb begin
        branch_inputs.rs1        = rs_data.rs1;
        branch_inputs.rs2        = rs_data.rs2;
        branch_inputs.pc         = entry.pc;
        branch_inputs.pc_offset  = dec.pc_offset;
        branch_inputs.fn3        = dec.fn3;
        branch_inputs.use_signed = dec.use_signed;
        branch_inputs.jal        = dec.jal;
        branch_inputs.jalr       = dec.jalr;
    end

endmodule

`default_nettype wire

// ==== files.f ====
design/issue_pkg.sv
design/instr_decoder.sv
design/issue_control.sv
design/operand_select.sv
design/decode_issue.sv
tests/decode_issue_chk.sv
tests/tb_decode_issue.sv

// ==== tests/decode_issue_chk.sv ====
////////////////////////////////////////
// Issue protocol assertions
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module decode_issue_chk (
    input logic                    clk,
    input logic                    rst,
    input issue_pkg::unit_vec_t    issue_to,
    input logic                    issue_hold,
    input logic                    fetch_flush,
    input logic                    instruction_issued,
    input issue_pkg::issue_entry_t entry
);
    import issue_pkg::*;

    int assert_failures = 0;

    assert property (@(posedge clk) disable iff (rst) $onehot0(issue_to))
        else begin
            $error("issue_to has more than one unit set");
            assert_failures++;
        end

    assert property (@(posedge clk) disable iff (rst)
        (issue_hold || fetch_flush) |-> (issue_to == '0))
        else begin
            $error("issue while hold or flush is high");
            assert_failures++;
        end

    // A waiting entry must not change
    assert property (@(posedge clk) disable iff (rst)
        (entry.valid && !instruction_issued && !fetch_flush) |=> $stable(entry))
        else begin
            $error("entry changed while waiting to issue");
            assert_failures++;
        end

endmodule

bind issue_control decode_issue_chk chk_i (
    .clk                (clk),
    .rst                (rst),
    .issue_to           (issue_to),
    .issue_hold         (issue_hold),
    .fetch_flush        (fetch_flush),
    .instruction_issued (instruction_issued),
    .entry              (entry)
);

`default_nettype wire

// ==== tests/issue_cases.txt ====
# instr pc rs1 rs2 busy(rs1,rs2) ready hold mode(0 run,1 flush,2 hold) unit in1 in2
# ls_offset pc_offset flags(fwd,signed,slt,sub) check(flags,pc,ls,alu)
123450B7 00001000 00000010 00000003 0 F 0 0 0 000000000 012345000 000 000000 4 9
00001117 00001000 00000010 00000003 0 F 0 0 0 000001000 000001000 000 000000 4 9
008000EF 00001000 00000010 00000003 0 F 0 0 1 000001000 000000004 000 000008 4 D
FF1FF06F 00001000 00000010 00000003 0 F 0 0 1 000001000 000000004 000 1FFFF0 0 D
00C280E7 00001000 00000010 00000003 0 F 0 0 1 000001000 000000004 000 00000C 4 D
FFC280E7 00001000 00000010 00000003 0 F 0 0 1 000001000 000000004 000 1FFFFC 4 D
FFB08193 00001000 00000010 00000003 0 F 0 0 0 000000010 1FFFFFFFB 000 000000 4 9
40208133 00001000 00000010 00000003 0 F 0 0 0 000000010 000000003 000 000000 5 9
0020B1B3 00001000 80000000 00000001 0 F 0 0 0 080000000 000000001 000 000000 7 9
0020A1B3 00001000 80000000 00000001 0 F 0 0 0 180000000 000000001 000 000000 7 9
0020C1B3 00001000 F0F0F0F0 0F0F0F0F 0 F 0 0 0 1F0F0F0F0 00F0F0F0F 000 000000 4 9
0080A283 00001000 00000010 00000003 0 F 0 0 2 000000000 000000000 008 000000 0 2
FFC0A283 00001000 00000010 00000003 0 F 0 0 2 000000000 000000000 FFC 000000 0 2
0020AA23 00001000 00000010 00000003 0 F 0 0 2 000000000 000000000 014 000000 0 2
FE20AC23 00001000 00000010 00000003 0 F 0 0 2 000000000 000000000 FF8 000000 0 2
0020AA23 00001000 00000010 00000003 1 F 0 0 2 000000000 000000000 014 000000 F A
0020AA23 00001000 00000010 00000003 2 F 3 0 2 000000000 000000000 014 000000 7 A
00208863 00001000 00000010 00000003 0 F 0 0 1 000000000 000000000 000 000010 4 C
FE208CE3 00001000 00000010 00000003 0 F 0 0 1 000000000 000000000 000 1FFFF8 4 C
0020E863 00001000 00000010 00000003 0 F 0 0 1 000000000 000000000 000 000010 0 C
0020F863 00001000 00000010 00000003 0 F 0 0 1 000000000 000000000 000 000010 0 C
0020C863 00001000 00000010 00000003 0 F 0 0 1 000000000 000000000 000 000010 4 C
00000073 00001000 00000010 00000003 0 F 0 0 3 000000000 000000000 000 000000 0 0
0FF0000F 00001000 00000010 00000003 0 F 0 0 3 000000000 000000000 000 000000 0 0
002081B3 00001000 00000010 00000003 0 E 4 0 0 000000010 000000003 000 000000 4 9
002081B3 00001000 00000010 00000003 1 F 3 0 0 000000010 000000003 000 000000 4 9
00508193 00001000 00000010 00000003 1 F 0 0 0 000000010 000000005 000 000000 4 9
00208863 00001000 00000010 00000003 2 F 2 0 1 000000000 000000000 000 000010 4 C
0080A283 00001000 00000010 00000003 0 B 3 0 2 000000000 000000000 008 000000 0 2
008000EF 00001000 00000010 00000003 0 D 2 0 1 000001000 000000004 000 000008 4 D
002081B3 00001000 00000010 00000003 0 F 0 1 0 000000000 000000000 000 000000 0 0
FFB08193 00001000 00000010 00000003 0 F 0 0 0 000000010 1FFFFFFFB 000 000000 4 9
002081B3 00001000 00000010 00000003 0 F 2 2 0 000000010 000000003 000 000000 4 9

// ==== tests/tb_decode_issue.sv ====
////////////////////////////////////////
// Case-file driven testbench for the
// decode and issue stage
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_decode_issue;
    import issue_pkg::*;

    localparam int MAX_CASES = 64;
    localparam int MAX_HOLD  = 4;

    logic           clk = 1'b0;
    logic           rst;
    decode_packet_t decode;
    logic           decode_advance;
    rs_data_t       rs_data;
    rs_busy_t       rs_busy;
    unit_vec_t      unit_ready;
    logic           fetch_flush;
    logic           issue_hold;
    unit_vec_t      issue_to;
    logic           instruction_issued;
    logic [1:0][REG_ADDR_W-1:0] rs_addr;
    alu_inputs_t    alu_inputs;
    ls_inputs_t     ls_inputs;
    branch_inputs_t branch_inputs;

    // Case table, one entry per line of the case file
    logic [31:0] c_instr [MAX_CASES];
    logic [31:0] c_pc    [MAX_CASES];
    logic [31:0] c_rs1   [MAX_CASES];
    logic [31:0] c_rs2   [MAX_CASES];
    logic [1:0]  c_busy  [MAX_CASES];
    logic [3:0]  c_ready [MAX_CASES];
    logic [3:0]  c_hold  [MAX_CASES];
    logic [1:0]  c_mode  [MAX_CASES];
    logic [1:0]  c_unit  [MAX_CASES];
    logic [32:0] c_in1   [MAX_CASES];
    logic [32:0] c_in2   [MAX_CASES];
    logic [11:0] c_ls    [MAX_CASES];
    logic [20:0] c_pcoff [MAX_CASES];
    logic [3:0]  c_flags [MAX_CASES];
    logic [3:0]  c_mask  [MAX_CASES];

    int          num_cases;
    int          errors;
    int          case_errors;
    int          failed_cases;
    int          cycles;
    int          cycle_limit;
    logic [31:0] lfsr_state;

    decode_issue UUT (
        .clk                (clk),
        .rst                (rst),
        .decode             (decode),
        .decode_advance     (decode_advance),
        .rs_data            (rs_data),
        .rs_busy            (rs_busy),
        .unit_ready         (unit_ready),
        .fetch_flush        (fetch_flush),
        .issue_hold         (issue_hold),
        .issue_to           (issue_to),
        .instruction_issued (instruction_issued),
        .rs_addr            (rs_addr),
        .alu_inputs         (alu_inputs),
        .ls_inputs          (ls_inputs),
        .branch_inputs      (branch_inputs)
    );

    always #4 clk = ~clk;

    // Hang guard, armed once the case count is known
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles > cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Helpers
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
            case_errors++;
        end
    endtask

    task automatic load_cases();
        int          fd;
        int          n;
        logic [8*256-1:0] line;
        fd = $fopen("tests/issue_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file tests/issue_cases.txt");
            errors++;
            return;
        end
        num_cases = 0;
        while (!$feof(fd) && num_cases < MAX_CASES) begin
            line = '0;
            void'($fgets(line, fd));
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        c_instr[num_cases], c_pc[num_cases], c_rs1[num_cases],
                        c_rs2[num_cases], c_busy[num_cases], c_ready[num_cases],
                        c_hold[num_cases], c_mode[num_cases], c_unit[num_cases],
                        c_in1[num_cases], c_in2[num_cases], c_ls[num_cases],
                        c_pcoff[num_cases], c_flags[num_cases], c_mask[num_cases]);
            // Comment and blank lines do not scan
            if (n == 15)
                num_cases++;
        end
        $fclose(fd);
    endtask

    task automatic check_issue(input int k);
        logic [3:0] got_flags;
        got_flags = {ls_inputs.forwarded_store, branch_inputs.use_signed,
                     alu_inputs.slt_path, alu_inputs.subtract};
        check_value("issue_to", 64'(issue_to), 64'(4'b0001 << c_unit[k]));
        // Register file read addresses come from the rs1 and rs2 fields
        check_value("rs_addr[0]", 64'(rs_addr[0]), 64'(c_instr[k][19:15]));
        check_value("rs_addr[1]", 64'(rs_addr[1]), 64'(c_instr[k][24:20]));
        if (c_mask[k][0]) begin
            check_value("alu_inputs.in1", 64'(alu_inputs.in1), 64'(c_in1[k]));
            check_value("alu_inputs.in2", 64'(alu_inputs.in2), 64'(c_in2[k]));
        end
        if (c_mask[k][1])
            check_value("ls_inputs.offset", 64'(ls_inputs.offset), 64'(c_ls[k]));
        if (c_mask[k][2])
            check_value("branch_inputs.pc_offset", 64'(branch_inputs.pc_offset),
                        64'(c_pcoff[k]));
        if (c_mask[k][3])
            check_value("flags", 64'(got_flags), 64'(c_flags[k]));
    endtask

    ////////////////////////////////////////
    // One case: accept, optional stall or flush, then issue
    task automatic run_case(input int k);
        int hold_n;
        int waited;
        case_errors = 0;
        @(posedge clk);
        decode      <= '{valid: 1'b1, pc: c_pc[k], instruction: c_instr[k]};
        rs_data     <= '{rs1: c_rs1[k], rs2: c_rs2[k]};
        rs_busy     <= c_busy[k];
        unit_ready  <= c_ready[k];
        do
            @(negedge clk);
        while (!decode_advance);
        // Accept edge
        @(posedge clk);
        if (c_mode[k] == 2'd1) begin
            decode      <= '0;
            fetch_flush <= 1'b1;
            @(negedge clk);
            check_value("issue_to", 64'(issue_to), 64'd0);
            @(posedge clk);
            fetch_flush <= 1'b0;
            repeat (2) begin
                @(negedge clk);
                check_value("instruction_issued", 64'(instruction_issued), 64'd0);
            end
        end else begin
            if (c_hold[k] != 0) begin
                random_bits(3, hold_n);
                hold_n = 1 + hold_n % int'(c_hold[k]);
                // Filler keeps decode valid so a blocked advance is visible
                decode <= '{valid: 1'b1, pc: c_pc[k] + 32'd4, instruction: 32'h0000_0013};
                if (c_mode[k] == 2'd2)
                    issue_hold <= 1'b1;
                for (int i = 0; i < hold_n; i++) begin
                    @(negedge clk);
                    check_value("issue_to", 64'(issue_to), 64'd0);
                    check_value("decode_advance", 64'(decode_advance), 64'd0);
                    @(posedge clk);
                end
                rs_busy    <= '0;
                unit_ready <= '1;
                issue_hold <= 1'b0;
            end
            decode <= '0;
            waited = 0;
            @(negedge clk);
            while (!instruction_issued) begin
                waited++;
                @(negedge clk);
            end
            if (c_hold[k] == 0 && waited != 0) begin
                $display("Case %0d issued %0d cycles later than one cycle after accept",
                         k, waited);
                errors++;
                case_errors++;
            end
            check_issue(k);
            @(negedge clk);
            check_value("instruction_issued", 64'(instruction_issued), 64'd0);
        end
        if (case_errors != 0)
            failed_cases++;
        $display("case %0d instr %h: %s", k, c_instr[k], case_errors ? "FAIL" : "ok");
    endtask

    initial begin
        rst          = 1'b1;
        decode       = '0;
        rs_data      = '0;
        rs_busy      = '0;
        unit_ready   = '1;
        fetch_flush  = 1'b0;
        issue_hold   = 1'b0;
        errors       = 0;
        failed_cases = 0;
        cycles       = 0;
        cycle_limit  = 0;
        num_cases    = 0;
        lfsr_state   = 32'he9bd;

        load_cases();
        cycle_limit = 40 + num_cases * (MAX_HOLD + 8);

        repeat (10) @(posedge clk);
        rst <= 1'b0;
        case_errors = 0;
        repeat (3) begin
            @(negedge clk);
            check_value("issue_to", 64'(issue_to), 64'd0);
            check_value("instruction_issued", 64'(instruction_issued), 64'd0);
        end
        $display("reset: %s", case_errors ? "FAIL" : "ok");

        for (int k = 0; k < num_cases; k++)
            run_case(k);

        errors += UUT.control_i.chk_i.assert_failures;
        $display("%0d cases, %0d failed, %0d assertion failures, %0d errors", num_cases,
                 failed_cases, UUT.control_i.chk_i.assert_failures, errors);
        if (errors == 0 && num_cases > 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire
